/* all.f */
rtl/core_pkg.sv
rtl/fetch_ctrl.sv
rtl/fetch_unit.sv
rtl/decode.sv
rtl/execute.sv
rtl/result.sv
rtl/core_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_top -f all.f -o tb_sim

# the log decides the outcome, so a nonzero exit of the binary is not fatal here
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int prog_words = 64;
    localparam int done_timeout = 3000;
    localparam int drain_cycles = 30;

    logic clk = 1'b0;
    logic rst;
    logic imem_req_valid;
    logic imem_req_ready;
    core_pkg::imem_req_t imem_req;
    logic imem_rsp_valid;
    logic imem_rsp_ready;
    core_pkg::imem_rsp_t imem_rsp;
    core_pkg::retire_t retire;

    core_pkg::word_t prog_mem [prog_words];
    int prog_len;
    int seed = 57;
    logic rand_mem;
    int test_num;
    logic test_start;
    logic test_end;
    logic done;
    int errors_total;
    int tests_failed;
    logic timed_out;

    // memory model state
    logic rst_seen;
    logic req_fire;
    logic rsp_fire;
    core_pkg::word_t req_addr;
    core_pkg::word_t pend_addr;
    logic pending = 1'b0;
    int wait_left;

    initial begin
        forever #2 clk = ~clk;
    end

    core_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .imem_req_valid (imem_req_valid),
        .imem_req_ready (imem_req_ready),
        .imem_req       (imem_req),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_ready (imem_rsp_ready),
        .imem_rsp       (imem_rsp),
        .retire         (retire)
    );

    tb_checker i_checker (
        .clk        (clk),
        .rst        (rst),
        .retire     (retire),
        .prog       (prog_mem),
        .test_num   (test_num),
        .test_start (test_start),
        .test_end   (test_end),
        .done       (done),
        .err_total  (errors_total),
        .fail_tests (tests_failed)
    );

    // handshakes are sampled on the falling edge and take effect at the next rise
    always begin
        @(negedge clk);
        rst_seen = rst;
        req_fire = imem_req_valid && imem_req_ready;
        rsp_fire = imem_rsp_valid && imem_rsp_ready;
        req_addr = imem_req.pc;
        @(posedge clk);
        #1;
        if (rst_seen) begin
            pending = 1'b0;
            imem_rsp_valid = 1'b0;
            imem_req_ready = 1'b0;
        end else begin
            if (rsp_fire) begin
                imem_rsp_valid = 1'b0;
            end
            if (req_fire) begin
                pending = 1'b1;
                pend_addr = req_addr;
                if (rand_mem) begin
                    wait_left = 1 + ($random(seed) & 3);
                end else begin
                    wait_left = 1;
                end
            end
            if (pending && !imem_rsp_valid) begin
                wait_left--;
                if (wait_left == 0) begin
                    imem_rsp_valid = 1'b1;
                    imem_rsp.instr = prog_mem[pend_addr[7:2]];
                    pending = 1'b0;
                end
            end
            if (rand_mem) begin
                imem_req_ready = ($random(seed) & 32'h3) != 0;
            end else begin
                imem_req_ready = 1'b1;
            end
        end
    end

    function automatic core_pkg::word_t r_type(input int f7, input int f3, input int rd,
                                               input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic core_pkg::word_t addi_instr(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic core_pkg::word_t branch_instr(input int f3, input int rs1, input int rs2,
                                                     input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic core_pkg::word_t jal_instr(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input core_pkg::word_t instr);
        prog_mem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic load_program(input int prog_id);
        int i;
        // addi x0 with the word index as immediate, never retires
        for (i = 0; i < prog_words; i++) begin
            prog_mem[i] = {i[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011};
        end
        prog_len = 0;
        case (prog_id)
            1: begin
                emit(addi_instr(1, 0, 5));
                emit(addi_instr(2, 0, -3));
                emit(r_type(7'h00, 3'h0, 3, 1, 2));
                emit(r_type(7'h20, 3'h0, 4, 1, 2));
                emit(r_type(7'h00, 3'h7, 5, 1, 2));
                emit(r_type(7'h00, 3'h6, 6, 1, 2));
                emit(r_type(7'h00, 3'h4, 7, 1, 2));
            end
            2: begin
                // each result feeds the next instruction
                emit(addi_instr(1, 0, 1));
                emit(addi_instr(1, 1, 2));
                emit(r_type(7'h00, 3'h0, 2, 1, 1));
                emit(r_type(7'h20, 3'h0, 3, 2, 1));
                emit(r_type(7'h00, 3'h4, 4, 3, 2));
                emit(addi_instr(4, 4, 100));
                emit(r_type(7'h00, 3'h6, 5, 4, 1));
            end
            3: begin
                emit(addi_instr(1, 0, 7));
                emit(addi_instr(2, 0, 7));
                emit(branch_instr(3'h0, 1, 2, 8));
                emit(addi_instr(3, 0, 99));
                emit(branch_instr(3'h1, 1, 2, 8));
                emit(addi_instr(4, 0, 11));
                emit(addi_instr(2, 2, 1));
                emit(branch_instr(3'h1, 1, 2, 8));
                emit(addi_instr(5, 0, 99));
                emit(branch_instr(3'h0, 1, 2, 8));
                emit(addi_instr(6, 0, 12));
            end
            4: begin
                emit(addi_instr(1, 0, 3));
                emit(jal_instr(2, 12));
                emit(addi_instr(3, 0, 99));
                emit(addi_instr(3, 0, 98));
                // countdown loop closed by a backward bne
                emit(addi_instr(1, 1, -1));
                emit(branch_instr(3'h1, 1, 0, -4));
                emit(jal_instr(5, 8));
                emit(addi_instr(6, 0, 99));
                emit(r_type(7'h00, 3'h0, 7, 2, 5));
            end
            default: begin
                emit(addi_instr(0, 0, 55));
                emit(addi_instr(1, 0, 9));
                emit(r_type(7'h00, 3'h0, 0, 1, 1));
                emit(r_type(7'h00, 3'h0, 2, 0, 1));
                emit(jal_instr(0, 8));
                emit(addi_instr(3, 0, 99));
                emit(r_type(7'h00, 3'h6, 4, 0, 0));
            end
        endcase
        // self jump ends the program
        emit(jal_instr(0, 0));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(input int prog_id, input logic rand_mode, output logic ok);
        int cycles;
        rst = 1'b1;
        next_cycle();
        load_program(prog_id);
        rand_mem = rand_mode;
        test_num++;
        test_start = 1'b1;
        next_cycle();
        test_start = 1'b0;
        repeat (3) next_cycle();
        rst = 1'b0;
        cycles = 0;
        while (!done && (cycles < done_timeout)) begin
            next_cycle();
            cycles++;
        end
        ok = done;
        if (!ok) begin
            $display("test %0d: timeout, retire trace incomplete after %0d cycles",
                     test_num, done_timeout);
        end else begin
            // keep watching for retires past the end of the trace
            repeat (drain_cycles) next_cycle();
        end
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    initial begin
        int mode;
        int prog_id;
        logic test_ok;
        rst = 1'b1;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp = '0;
        rand_mem = 1'b0;
        test_start = 1'b0;
        test_end = 1'b0;
        test_num = 0;
        timed_out = 1'b0;
        for (mode = 0; mode < 2; mode++) begin
            for (prog_id = 1; prog_id <= 5; prog_id++) begin
                if (!timed_out) begin
                    run_test(prog_id, mode == 1, test_ok);
                    timed_out = !test_ok;
                end
            end
        end
        $display("%0d tests run, %0d failed, %0d errors", test_num, tests_failed, errors_total);
        if (timed_out || (errors_total != 0) || (tests_failed != 0)) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule

/* testbench/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::retire_t  retire,
    input  core_pkg::word_t    prog [64],
    input  int                 test_num,
    input  logic               test_start,
    input  logic               test_end,
    output logic               done,
    output int                 err_total,
    output int                 fail_tests
);

    localparam int max_steps = 500;

    core_pkg::retire_t exp_q [$];
    core_pkg::word_t ref_regs [32];
    int exp_idx = 0;
    int test_errs = 0;
    logic armed = 1'b0;

    initial begin
        done = 1'b0;
        err_total = 0;
        fail_tests = 0;
    end

    // architectural model of one instruction, returns the next pc
    function automatic core_pkg::word_t ref_step(input core_pkg::word_t pc,
                                                 output core_pkg::retire_t ret);
        core_pkg::word_t ins;
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t imm_i;
        core_pkg::word_t imm_b;
        core_pkg::word_t imm_j;
        core_pkg::word_t val;
        core_pkg::word_t nxt;
        logic [9:0] fn;
        logic wr;
        ins = prog[pc[7:2]];
        a = ref_regs[ins[19:15]];
        b = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        fn = {ins[31:25], ins[14:12]};
        nxt = pc + 32'd4;
        val = '0;
        wr = 1'b0;
        case (ins[6:0])
            7'b0110011: begin
                wr = 1'b1;
                case (fn)
                    {7'h00, 3'h0}: val = a + b;
                    {7'h20, 3'h0}: val = a - b;
                    {7'h00, 3'h4}: val = a ^ b;
                    {7'h00, 3'h6}: val = a | b;
                    {7'h00, 3'h7}: val = a & b;
                    default: wr = 1'b0;
                endcase
            end
            7'b0010011: begin
                if (ins[14:12] == 3'h0) begin
                    wr = 1'b1;
                    val = a + imm_i;
                end
            end
            7'b1100011: begin
                if ((ins[14:12] == 3'h0) && (a == b)) begin
                    nxt = pc + imm_b;
                end else if ((ins[14:12] == 3'h1) && (a != b)) begin
                    nxt = pc + imm_b;
                end
            end
            7'b1101111: begin
                wr = 1'b1;
                val = pc + 32'd4;
                nxt = pc + imm_j;
            end
            default: wr = 1'b0;
        endcase
        ret.valid = wr && (ins[11:7] != 5'd0);
        ret.pc = pc;
        ret.rd = ins[11:7];
        ret.value = val;
        if (ret.valid) begin
            ref_regs[ins[11:7]] = val;
        end
        return nxt;
    endfunction

    // run from the reset pc until a self jump, collecting every register write
    task automatic build_trace();
        core_pkg::word_t pc;
        core_pkg::word_t nxt;
        core_pkg::retire_t ret;
        int i;
        exp_q.delete();
        for (i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        pc = '0;
        for (i = 0; i < max_steps; i++) begin
            nxt = ref_step(pc, ret);
            if (ret.valid) begin
                exp_q.push_back(ret);
            end
            if (nxt == pc) begin
                break;
            end
            pc = nxt;
        end
    endtask

    task automatic note_error();
        test_errs++;
        err_total++;
    endtask

    task automatic check_field(input string name, input core_pkg::word_t got,
                               input core_pkg::word_t want);
        if (got !== want) begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, want);
            note_error();
        end
    endtask

    // retire is registered, so the falling edge sees settled values
    always @(negedge clk) begin
        if (test_start) begin
            build_trace();
            exp_idx = 0;
            test_errs = 0;
            armed = 1'b1;
        end
        if (rst) begin
            if (retire.valid === 1'b1) begin
                $display("%0t: retire is valid while reset is asserted", $time);
                note_error();
            end
        end else if (retire.valid === 1'b1) begin
            if (!armed || (exp_idx >= exp_q.size())) begin
                $display("%0t: extra retire of x%0d at pc %h beyond the expected trace",
                         $time, retire.rd, retire.pc);
                note_error();
            end else begin
                check_field("retire.pc", retire.pc, exp_q[exp_idx].pc);
                check_field("retire.rd", {27'd0, retire.rd}, {27'd0, exp_q[exp_idx].rd});
                check_field("retire.value", retire.value, exp_q[exp_idx].value);
                exp_idx++;
            end
        end else if (retire.valid !== 1'b0) begin
            $display("%0t: retire valid is unknown", $time);
            note_error();
        end
        if (test_end) begin
            if (exp_idx != exp_q.size()) begin
                $display("test %0d: only %0d of %0d expected retires seen",
                         test_num, exp_idx, exp_q.size());
                note_error();
            end
            if (test_errs == 0) begin
                $display("test %0d: ok, %0d retires checked", test_num, exp_idx);
            end else begin
                $display("test %0d: FAILED with %0d errors", test_num, test_errs);
                fail_tests++;
            end
            armed = 1'b0;
        end
        done = armed && (exp_idx == exp_q.size());
    end

endmodule

/* rtl/core_top.sv */
`timescale 1ns/1ps

module core_top (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 imem_req_valid,
    input  logic                 imem_req_ready,
    output core_pkg::imem_req_t  imem_req,
    input  logic                 imem_rsp_valid,
    output logic                 imem_rsp_ready,
    input  core_pkg::imem_rsp_t  imem_rsp,
    output core_pkg::retire_t    retire
);

    core_pkg::fe_ctrl_t fe_ctrl;
    core_pkg::word_t instr_dec;
    core_pkg::word_t pc_dec;
    logic valid_dec;
    logic flow_dec;
    core_pkg::dec_t dec;
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::word_t rs1_val;
    core_pkg::word_t rs2_val;
    core_pkg::exe_t exe;
    core_pkg::exe_t fwd;
    core_pkg::word_t pc_exe;
    logic valid_exe;
    logic taken_exe;
    core_pkg::word_t target_exe;

    fetch_ctrl i_fetch_ctrl (
        .clk            (clk),
        .rst            (rst),
        .imem_req_valid (imem_req_valid),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_ready (imem_rsp_ready),
        .flow_dec       (flow_dec),
        .pc_dec         (pc_dec),
        .pc_exe         (pc_exe),
        .valid_exe      (valid_exe),
        .taken_exe      (taken_exe),
        .fe_ctrl        (fe_ctrl)
    );

    fetch_unit i_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .fe_ctrl        (fe_ctrl),
        .target_exe     (target_exe),
        .imem_req       (imem_req),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_ready (imem_rsp_ready),
        .imem_rsp       (imem_rsp),
        .instr_dec      (instr_dec),
        .pc_dec         (pc_dec),
        .valid_dec      (valid_dec)
    );

    decode i_decode (
        .instr_dec (instr_dec),
        .pc_dec    (pc_dec),
        .valid_dec (valid_dec),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .flow_dec  (flow_dec),
        .dec       (dec)
    );

    execute i_execute (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .fwd        (fwd),
        .exe        (exe),
        .pc_exe     (pc_exe),
        .valid_exe  (valid_exe),
        .taken_exe  (taken_exe),
        .target_exe (target_exe)
    );

    result i_result (
        .clk      (clk),
        .rst      (rst),
        .exe      (exe),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .fwd      (fwd),
        .retire   (retire)
    );

endmodule

/* rtl/result.sv */
`timescale 1ns/1ps

module result (
    input  logic                 clk,
    input  logic                 rst,
    input  core_pkg::exe_t       exe,
    input  core_pkg::reg_addr_t  rs1_addr,
    input  core_pkg::reg_addr_t  rs2_addr,
    output core_pkg::word_t      rs1_val,
    output core_pkg::word_t      rs2_val,
    output core_pkg::exe_t       fwd,
    output core_pkg::retire_t    retire
);

    core_pkg::exe_t wb_q;
    core_pkg::word_t rf [core_pkg::reg_cnt];

    // x0 reads zero, a pending writeback is seen in the same cycle
    function automatic core_pkg::word_t rf_read(input core_pkg::reg_addr_t addr);
        core_pkg::word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wb_q.valid && (wb_q.rd == addr)) begin
            val = wb_q.value;
        end else begin
            val = rf[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        wb_q <= exe;
        if (rst) begin
            wb_q.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_q.valid) begin
            rf[wb_q.rd] <= wb_q.value;
        end
    end

    always_comb begin
        rs1_val = rf_read(rs1_addr);
        rs2_val = rf_read(rs2_addr);
    end

    assign fwd = wb_q;

    assign retire.valid = wb_q.valid;
    assign retire.pc = wb_q.pc;
    assign retire.rd = wb_q.rd;
    assign retire.value = wb_q.value;

    // execute must filter x0 writes before they reach writeback
    a_retire_no_x0: assert property (
        @(posedge clk) disable iff (rst)
        retire.valid |-> (retire.rd != '0)
    );

endmodule

/* rtl/execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic             clk,
    input  logic             rst,
    input  core_pkg::dec_t   dec,
    input  core_pkg::exe_t   fwd,
    output core_pkg::exe_t   exe,
    output core_pkg::word_t  pc_exe,
    output logic             valid_exe,
    output logic             taken_exe,
    output core_pkg::word_t  target_exe
);

    core_pkg::dec_t ex_q;
    core_pkg::word_t op_a;
    core_pkg::word_t op_b;
    core_pkg::word_t alu_out;
    logic writes_rd;
    logic cond;

    always_ff @(posedge clk) begin
        ex_q <= dec;
        if (rst) begin
            ex_q.valid <= 1'b0;
        end
    end

    // result stage holds the instruction just ahead, newer than the regfile read
    assign op_a = (fwd.valid && (fwd.rd == ex_q.rs1)) ? fwd.value : ex_q.rs1_val;
    assign op_b = (fwd.valid && (fwd.rd == ex_q.rs2)) ? fwd.value : ex_q.rs2_val;

    always_comb begin
        alu_out = '0;
        writes_rd = 1'b1;
        cond = 1'b0;
        case (ex_q.op)
            core_pkg::op_add:  alu_out = op_a + op_b;
            core_pkg::op_sub:  alu_out = op_a - op_b;
            core_pkg::op_and:  alu_out = op_a & op_b;
            core_pkg::op_or:   alu_out = op_a | op_b;
            core_pkg::op_xor:  alu_out = op_a ^ op_b;
            core_pkg::op_addi: alu_out = op_a + ex_q.imm;
            core_pkg::op_beq: begin
                writes_rd = 1'b0;
                cond = (op_a == op_b);
            end
            core_pkg::op_bne: begin
                writes_rd = 1'b0;
                cond = (op_a != op_b);
            end
            core_pkg::op_jal: begin
                // link address
                alu_out = ex_q.pc + 32'd4;
                cond = 1'b1;
            end
            default: writes_rd = 1'b0;
        endcase
    end

    assign exe.valid = ex_q.valid && writes_rd && (ex_q.rd != '0);
    assign exe.pc = ex_q.pc;
    assign exe.rd = ex_q.rd;
    assign exe.value = alu_out;

    assign pc_exe = ex_q.pc;
    assign valid_exe = ex_q.valid;
    assign taken_exe = ex_q.valid && cond;
    // branch and jal targets are both pc relative
    assign target_exe = ex_q.pc + ex_q.imm;

endmodule

/* rtl/decode.sv */
`timescale 1ns/1ps

module decode (
    input  core_pkg::word_t      instr_dec,
    input  core_pkg::word_t      pc_dec,
    input  logic                 valid_dec,
    output core_pkg::reg_addr_t  rs1_addr,
    output core_pkg::reg_addr_t  rs2_addr,
    input  core_pkg::word_t      rs1_val,
    input  core_pkg::word_t      rs2_val,
    output logic                 flow_dec,
    output core_pkg::dec_t       dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    core_pkg::opcode_t op;
    core_pkg::word_t imm;

    assign opcode = instr_dec[6:0];
    assign funct3 = instr_dec[14:12];
    assign funct7 = instr_dec[31:25];
    assign rs1_addr = instr_dec[19:15];
    assign rs2_addr = instr_dec[24:20];

    always_comb begin
        op = core_pkg::op_nop;
        imm = '0;
        case (opcode)
            core_pkg::opc_reg: begin
                case (funct3)
                    core_pkg::f3_add_sub: begin
                        if (funct7 == core_pkg::f7_base) begin
                            op = core_pkg::op_add;
                        end else if (funct7 == core_pkg::f7_alt) begin
                            op = core_pkg::op_sub;
                        end
                    end
                    core_pkg::f3_xor: begin
                        if (funct7 == core_pkg::f7_base) begin
                            op = core_pkg::op_xor;
                        end
                    end
                    core_pkg::f3_or: begin
                        if (funct7 == core_pkg::f7_base) begin
                            op = core_pkg::op_or;
                        end
                    end
                    core_pkg::f3_and: begin
                        if (funct7 == core_pkg::f7_base) begin
                            op = core_pkg::op_and;
                        end
                    end
                    default: op = core_pkg::op_nop;
                endcase
            end
            core_pkg::opc_imm: begin
                imm = {{20{instr_dec[31]}}, instr_dec[31:20]};
                if (funct3 == core_pkg::f3_add_sub) begin
                    op = core_pkg::op_addi;
                end
            end
            core_pkg::opc_branch: begin
                imm = {{20{instr_dec[31]}}, instr_dec[7], instr_dec[30:25],
                       instr_dec[11:8], 1'b0};
                if (funct3 == core_pkg::f3_beq) begin
                    op = core_pkg::op_beq;
                end else if (funct3 == core_pkg::f3_bne) begin
                    op = core_pkg::op_bne;
                end
            end
            core_pkg::opc_jal: begin
                imm = {{12{instr_dec[31]}}, instr_dec[19:12], instr_dec[20],
                       instr_dec[30:21], 1'b0};
                op = core_pkg::op_jal;
            end
            default: op = core_pkg::op_nop;
        endcase
    end

    // front-end has to wait for these to resolve in execute
    assign flow_dec = valid_dec && ((op == core_pkg::op_beq) || (op == core_pkg::op_bne) ||
                                    (op == core_pkg::op_jal));

    assign dec.valid = valid_dec;
    assign dec.pc = pc_dec;
    assign dec.op = op;
    assign dec.rd = instr_dec[11:7];
    assign dec.rs1 = rs1_addr;
    assign dec.rs2 = rs2_addr;
    assign dec.rs1_val = rs1_val;
    assign dec.rs2_val = rs2_val;
    assign dec.imm = imm;

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  core_pkg::fe_ctrl_t   fe_ctrl,
    input  core_pkg::word_t      target_exe,
    output core_pkg::imem_req_t  imem_req,
    input  logic                 imem_rsp_valid,
    input  logic                 imem_rsp_ready,
    input  core_pkg::imem_rsp_t  imem_rsp,
    output core_pkg::word_t      instr_dec,
    output core_pkg::word_t      pc_dec,
    output logic                 valid_dec
);

    core_pkg::word_t pc_q;
    core_pkg::word_t pc_nx;
    logic rsp_hs;

    assign rsp_hs = imem_rsp_valid && imem_rsp_ready;

    always_comb begin
        case (fe_ctrl.pc_sel)
            core_pkg::pc_sel_pc:   pc_nx = pc_q;
            core_pkg::pc_sel_inc4: pc_nx = pc_q + 32'd4;
            core_pkg::pc_sel_alu:  pc_nx = target_exe;
            default:               pc_nx = pc_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= core_pkg::reset_pc;
        end else if (fe_ctrl.pc_we) begin
            pc_q <= pc_nx;
        end
    end

    // pc stays put between request and response, so it tags the response
    assign imem_req.pc = pc_q;

    always_ff @(posedge clk) begin
        if (rst || fe_ctrl.bubble_dec) begin
            valid_dec <= 1'b0;
        end else if (rsp_hs) begin
            valid_dec <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_hs) begin
            instr_dec <= imem_rsp.instr;
            pc_dec <= pc_q;
        end
    end

endmodule

/* rtl/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                clk,
    input  logic                rst,
    output logic                imem_req_valid,
    input  logic                imem_req_ready,
    input  logic                imem_rsp_valid,
    output logic                imem_rsp_ready,
    input  logic                flow_dec,
    input  core_pkg::word_t     pc_dec,
    input  core_pkg::word_t     pc_exe,
    input  logic                valid_exe,
    input  logic                taken_exe,
    output core_pkg::fe_ctrl_t  fe_ctrl
);

    typedef enum logic [1:0] {
        fc_rst,
        fc_steady,
        fc_stall_flow,
        fc_stall_ic
    } fc_state_t;

    fc_state_t state;
    fc_state_t state_nx;

    // pc of the branch or jump the front-end is waiting on
    core_pkg::word_t flow_pc;
    logic flow_save;
    logic flow_res;

    // decode was loaded by the last response and still holds it
    logic dec_full;

    assign flow_res = valid_exe && (pc_exe == flow_pc);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fc_rst;
        end else begin
            state <= state_nx;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flow_pc <= core_pkg::reset_pc;
        end else if (flow_save) begin
            flow_pc <= pc_dec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_full <= 1'b0;
        end else begin
            dec_full <= (state == fc_stall_ic) && imem_rsp_valid;
        end
    end

    always_comb begin
        state_nx = state;
        flow_save = 1'b0;
        fe_ctrl.pc_sel = core_pkg::pc_sel_pc;
        fe_ctrl.pc_we = 1'b0;
        // decode empties unless a response lands this cycle
        fe_ctrl.bubble_dec = 1'b1;
        imem_req_valid = 1'b0;
        imem_rsp_ready = 1'b0;

        case (state)
            fc_rst: begin
                // first request goes out with the reset pc
                imem_req_valid = 1'b1;
                imem_rsp_ready = 1'b1;
                if (imem_req_ready) begin
                    state_nx = fc_stall_ic;
                end
            end

            fc_stall_ic: begin
                imem_rsp_ready = 1'b1;
                if (imem_rsp_valid) begin
                    fe_ctrl.bubble_dec = 1'b0;
                    state_nx = fc_steady;
                end
            end

            fc_steady: begin
                if (flow_dec) begin
                    // hold fetch until execute resolves the flow change
                    flow_save = 1'b1;
                    state_nx = fc_stall_flow;
                end else if (dec_full) begin
                    fe_ctrl.pc_sel = core_pkg::pc_sel_inc4;
                    fe_ctrl.pc_we = 1'b1;
                end else begin
                    imem_req_valid = 1'b1;
                    if (imem_req_ready) begin
                        state_nx = fc_stall_ic;
                    end
                end
            end

            fc_stall_flow: begin
                if (flow_res) begin
                    fe_ctrl.pc_sel = taken_exe ? core_pkg::pc_sel_alu : core_pkg::pc_sel_inc4;
                    fe_ctrl.pc_we = 1'b1;
                    state_nx = fc_steady;
                end
            end

            default: begin
                state_nx = fc_rst;
            end
        endcase
    end

    // a pending request is held until memory accepts it
    a_req_held: assert property (
        @(posedge clk) disable iff (rst)
        imem_req_valid && !imem_req_ready |=> imem_req_valid
    );

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    localparam int xlen = 32;
    localparam int reg_cnt = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    localparam word_t reset_pc = '0;

    // rv32i major opcodes of the supported subset
    localparam logic [6:0] opc_reg = 7'b0110011;
    localparam logic [6:0] opc_imm = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal = 7'b1101111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt = 7'b0100000;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_beq,
        op_bne,
        op_jal,
        op_nop
    } opcode_t;

    typedef enum logic [1:0] {
        pc_sel_pc,
        pc_sel_inc4,
        pc_sel_alu
    } pc_sel_t;

    typedef struct packed {
        pc_sel_t pc_sel;
        logic    pc_we;
        logic    bubble_dec;
    } fe_ctrl_t;

    typedef struct packed {
        word_t pc;
    } imem_req_t;

    typedef struct packed {
        word_t instr;
    } imem_rsp_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        opcode_t   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
    } dec_t;

    // valid only for instructions that write a nonzero rd
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     value;
    } exe_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     value;
    } retire_t;

endpackage
